// ==== source/vmul_config.svh ====
// Build-time parameters of the vector multiply unit
// Queue depths, pipeline latency and field widths

`ifndef VMUL_CONFIG_SVH
`define VMUL_CONFIG_SVH

// Instruction queue entries
`define VMUL_INSN_QUEUE_DEPTH 4

// Result queue entries
`define VMUL_RESULT_QUEUE_DEPTH 2

// Multiplier pipeline stages
`define VMUL_MUL_LATENCY 2

// Element word width in bits
`define VMUL_ELEN 64

// Number of instruction IDs
`define VMUL_NR_VINSN 8

// Vector length and register-file address widths
`define VMUL_VLEN_W 10
`define VMUL_ADDR_W 8

`endif

// ==== source/vmul_op_pkg.sv ====
// Instruction-side types of the vector multiply unit
// Operation codes, element widths and the queued instruction descriptor

`include "vmul_config.svh"

package vmul_op_pkg;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMULHU = 2'd1,
    VMACC  = 2'd2
  } vmul_op_e;

  typedef logic [$clog2(`VMUL_NR_VINSN)-1:0] vid_t;
  typedef logic [`VMUL_VLEN_W-1:0]           vlen_t;
  typedef logic [`VMUL_ADDR_W-1:0]           vaddr_t;

  typedef struct packed {
    vid_t                  id;
    vmul_op_e              op;
    vew_e                  vsew;
    vlen_t                 vl;
    // Base word address of the destination register
    vaddr_t                vd;
    // High for an unmasked instruction
    logic                  vm;
    logic                  use_scalar_op;
    logic [`VMUL_ELEN-1:0] scalar_op;
  } vmul_insn_t;

endpackage

// ==== source/vmul_data_pkg.sv ====
// Data-side types of the vector multiply unit
// Element word views, byte strobes, multiplier bundles and results

`include "vmul_config.svh"

package vmul_data_pkg;

  import vmul_op_pkg::*;

  // One element word, read as bytes, halves, words or a double word
  typedef union packed {
    logic [7:0][7:0]  bytes;
    logic [3:0][15:0] halves;
    logic [1:0][31:0] words;
    logic [63:0]      dword;
  } elem_word_u;

  typedef logic [`VMUL_ELEN/8-1:0] strb_t;

  typedef struct packed {
    elem_word_u a;
    elem_word_u b;
    elem_word_u c;
    vmul_op_e   op;
    vew_e       vsew;
    strb_t      mask;
  } mul_req_t;

  typedef struct packed {
    elem_word_u result;
    strb_t      mask;
  } mul_rsp_t;

  typedef struct packed {
    vid_t       id;
    vaddr_t     addr;
    elem_word_u wdata;
    strb_t      be;
  } result_t;

  // Byte strobes of the elements still left in a word
  function automatic strb_t elem_strb(vlen_t left, vew_e vsew);
    logic [3:0] nbytes;
    nbytes = 4'd8;
    if (left < vlen_t'(4'd8 >> vsew)) begin
      nbytes = 4'(left << vsew);
    end
    return ~(strb_t'('1) << nbytes);
  endfunction

endpackage

// ==== source/vmul_insn_ctrl.sv ====
// Instruction queue controller of the vector multiply unit
// Tracks accept, issue, processing and commit phases and issues words

`timescale 1ns/10ps

`include "vmul_config.svh"

module vmul_insn_ctrl
  import vmul_op_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vmul_insn_t                insn_i,
  input  logic                      insn_valid_i,
  output logic                      insn_ready_o,
  input  logic [2:0]                operand_valid_i,
  output logic [2:0]                operand_ready_o,
  input  logic                      mask_valid_i,
  output logic                      mask_ready_o,
  input  logic                      mul_in_ready_i,
  output logic                      mul_in_valid_o,
  output vmul_insn_t                issue_insn_o,
  output vmul_insn_t                proc_insn_o,
  output vew_e                      commit_vsew_o,
  output vlen_t                     next_issue_vl_o,
  output vlen_t                     next_proc_vl_o,
  output vlen_t                     next_commit_vl_o,
  input  logic                      proc_fire_i,
  input  logic                      commit_fire_i,
  input  logic                      issue_last_i,
  input  logic                      proc_last_i,
  input  logic                      commit_last_i,
  output logic                      accept_o,
  output logic                      issue_fire_o,
  output logic [`VMUL_NR_VINSN-1:0] vinsn_done_o
);

  localparam int unsigned Depth = `VMUL_INSN_QUEUE_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [PtrW:0]   cnt_t;

  typedef struct packed {
    ptr_t accept_pnt;
    ptr_t issue_pnt;
    ptr_t proc_pnt;
    ptr_t commit_pnt;
    cnt_t issue_cnt;
    cnt_t proc_cnt;
    cnt_t commit_cnt;
  } queue_state_t;

  vmul_insn_t [Depth-1:0] queue_q;
  queue_state_t           state_d, state_q;
  vmul_insn_t             commit_insn;
  logic                   need_vs1, need_vd, need_mask;
  logic                   issue_done, proc_done, commit_done;

  // The commit count covers every occupied slot
  assign insn_ready_o = (state_q.commit_cnt != cnt_t'(Depth));
  assign accept_o     = insn_valid_i & insn_ready_o;

  assign issue_insn_o  = queue_q[state_q.issue_pnt];
  assign proc_insn_o   = queue_q[state_q.proc_pnt];
  assign commit_insn   = queue_q[state_q.commit_pnt];
  assign commit_vsew_o = commit_insn.vsew;

  // vl of the instruction that follows in each phase, zero if none waits
  assign next_issue_vl_o  = (state_q.issue_cnt > 1) ?
                            queue_q[ptr_t'(state_q.issue_pnt + 1'b1)].vl : '0;
  assign next_proc_vl_o   = (state_q.proc_cnt > 1) ?
                            queue_q[ptr_t'(state_q.proc_pnt + 1'b1)].vl : '0;
  assign next_commit_vl_o = (state_q.commit_cnt > 1) ?
                            queue_q[ptr_t'(state_q.commit_pnt + 1'b1)].vl : '0;

  // Operands this instruction consumes
  assign need_vs1  = ~issue_insn_o.use_scalar_op;
  assign need_vd   = (issue_insn_o.op == VMACC);
  assign need_mask = ~issue_insn_o.vm;

  assign mul_in_valid_o = (state_q.issue_cnt != '0) &&
                          (operand_valid_i[0] || !need_vs1) &&
                          operand_valid_i[1] &&
                          (operand_valid_i[2] || !need_vd) &&
                          (mask_valid_i || !need_mask);
  assign issue_fire_o   = mul_in_valid_o & mul_in_ready_i;

  assign operand_ready_o = issue_fire_o ? {need_vd, 1'b1, need_vs1} : 3'b000;
  assign mask_ready_o    = issue_fire_o & need_mask;

  assign issue_done  = issue_fire_o & issue_last_i;
  assign proc_done   = proc_fire_i & proc_last_i;
  assign commit_done = commit_fire_i & commit_last_i;

  always_comb begin
    state_d      = state_q;
    vinsn_done_o = '0;

    if (accept_o) begin
      state_d.accept_pnt = state_q.accept_pnt + 1'b1;
    end
    if (issue_done) begin
      state_d.issue_pnt = state_q.issue_pnt + 1'b1;
    end
    if (proc_done) begin
      state_d.proc_pnt = state_q.proc_pnt + 1'b1;
    end
    if (commit_done) begin
      state_d.commit_pnt = state_q.commit_pnt + 1'b1;
      vinsn_done_o[commit_insn.id] = 1'b1;
    end

    state_d.issue_cnt  = state_q.issue_cnt + cnt_t'(accept_o) - cnt_t'(issue_done);
    state_d.proc_cnt   = state_q.proc_cnt + cnt_t'(accept_o) - cnt_t'(proc_done);
    state_d.commit_cnt = state_q.commit_cnt + cnt_t'(accept_o) - cnt_t'(commit_done);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      queue_q[state_q.accept_pnt] <= insn_i;
    end
  end

endmodule

// ==== source/vmul_elem_counter.sv ====
// Remaining-element counters of the vector multiply unit
// One counter each for the issue, processing and commit phases

`timescale 1ns/10ps

module vmul_elem_counter
  import vmul_op_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  accept_i,
  input  vlen_t new_vl_i,
  input  logic  issue_fire_i,
  input  logic  proc_fire_i,
  input  logic  commit_fire_i,
  input  vew_e  issue_vsew_i,
  input  vew_e  proc_vsew_i,
  input  vew_e  commit_vsew_i,
  input  vlen_t next_issue_vl_i,
  input  vlen_t next_proc_vl_i,
  input  vlen_t next_commit_vl_i,
  output logic  issue_last_o,
  output logic  proc_last_o,
  output logic  commit_last_o,
  output vlen_t issue_left_o,
  output vlen_t proc_left_o
);

  // Index 0 is issue, 1 is processing, 2 is commit
  vlen_t [2:0]      cnt_d, cnt_q;
  vlen_t [2:0]      next_vl;
  logic  [2:0]      fire, last;
  logic  [2:0][3:0] per_word;
  vew_e             vsew [3];

  assign fire    = {commit_fire_i, proc_fire_i, issue_fire_i};
  assign next_vl = {next_commit_vl_i, next_proc_vl_i, next_issue_vl_i};
  assign vsew[0] = issue_vsew_i;
  assign vsew[1] = proc_vsew_i;
  assign vsew[2] = commit_vsew_i;

  always_comb begin
    for (int p = 0; p < 3; p++) begin
      per_word[p] = 4'd8 >> vsew[p];
      last[p]     = (cnt_q[p] <= vlen_t'(per_word[p]));
      cnt_d[p]    = cnt_q[p];
      if (fire[p]) begin
        cnt_d[p] = last[p] ? next_vl[p] : cnt_q[p] - vlen_t'(per_word[p]);
      end
      // An idle phase takes the new instruction straight away
      if (accept_i && cnt_d[p] == '0) begin
        cnt_d[p] = new_vl_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign issue_last_o  = last[0];
  assign proc_last_o   = last[1];
  assign commit_last_o = last[2];
  assign issue_left_o  = cnt_q[0];
  assign proc_left_o   = cnt_q[1];

endmodule

// ==== source/vmul_simd_mul.sv ====
// SIMD integer multiplier for 8, 16, 32 and 64 bit elements
// Stallable pipeline that carries the byte mask along with each word

`timescale 1ns/10ps

`include "vmul_config.svh"

module vmul_simd_mul
  import vmul_op_pkg::*;
  import vmul_data_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mul_req_t req_i,
  input  logic     valid_i,
  output logic     ready_o,
  output mul_rsp_t rsp_o,
  output logic     valid_o,
  input  logic     ready_i
);

  localparam int unsigned Lat = `VMUL_MUL_LATENCY;

  mul_rsp_t [Lat-1:0] stage_q;
  logic     [Lat-1:0] valid_q;
  mul_rsp_t           stage_in;
  logic               advance;

  // Per-element products over the union views
  always_comb begin
    logic [15:0]  p16;
    logic [31:0]  p32;
    logic [63:0]  p64;
    logic [127:0] p128;
    logic         high, acc;

    high          = (req_i.op == VMULHU);
    acc           = (req_i.op == VMACC);
    stage_in.mask = req_i.mask;
    stage_in.result.dword = '0;

    case (req_i.vsew)
      EW8: begin
        for (int i = 0; i < 8; i++) begin
          p16 = req_i.a.bytes[i] * req_i.b.bytes[i];
          stage_in.result.bytes[i] = high ? p16[15:8] :
                                     p16[7:0] + (acc ? req_i.c.bytes[i] : 8'h00);
        end
      end
      EW16: begin
        for (int i = 0; i < 4; i++) begin
          p32 = req_i.a.halves[i] * req_i.b.halves[i];
          stage_in.result.halves[i] = high ? p32[31:16] :
                                      p32[15:0] + (acc ? req_i.c.halves[i] : 16'h0);
        end
      end
      EW32: begin
        for (int i = 0; i < 2; i++) begin
          p64 = req_i.a.words[i] * req_i.b.words[i];
          stage_in.result.words[i] = high ? p64[63:32] :
                                     p64[31:0] + (acc ? req_i.c.words[i] : 32'h0);
        end
      end
      default: begin
        p128 = req_i.a.dword * req_i.b.dword;
        stage_in.result.dword = high ? p128[127:64] :
                                p128[63:0] + (acc ? req_i.c.dword : 64'h0);
      end
    endcase
  end

  // Every stage holds while the last one waits on the consumer
  assign advance = ready_i | ~valid_q[Lat-1];
  assign ready_o = advance;
  assign valid_o = valid_q[Lat-1];
  assign rsp_o   = stage_q[Lat-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q[0] <= valid_i;
      for (int s = 1; s < Lat; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      stage_q[0] <= stage_in;
      for (int s = 1; s < Lat; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

endmodule

// ==== source/vmul_result_queue.sv ====
// Result queue of the vector multiply unit
// Forms address and strobes per word and drives the register-file write port

`timescale 1ns/10ps

`include "vmul_config.svh"

module vmul_result_queue
  import vmul_op_pkg::*;
  import vmul_data_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  mul_rsp_t   rsp_i,
  input  logic       rsp_valid_i,
  output logic       rsp_ready_o,
  input  vmul_insn_t proc_insn_i,
  input  vlen_t      proc_left_i,
  output logic       proc_fire_o,
  output result_t    result_o,
  output logic       result_req_o,
  input  logic       result_gnt_i,
  output logic       commit_fire_o
);

  localparam int unsigned Depth = `VMUL_RESULT_QUEUE_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

  result_t [Depth-1:0] queue_q;
  logic    [PtrW-1:0]  wr_pnt_q, rd_pnt_q;
  logic    [PtrW:0]    cnt_q;
  vlen_t               done_elems;
  vaddr_t              word_idx;
  strb_t               be;

  assign rsp_ready_o = (cnt_q != Depth);
  assign proc_fire_o = rsp_valid_i & rsp_ready_o;

  // Word index from the elements already processed
  assign done_elems = proc_insn_i.vl - proc_left_i;
  assign word_idx   = vaddr_t'(done_elems >> (3 - int'(proc_insn_i.vsew)));
  assign be         = elem_strb(proc_left_i, proc_insn_i.vsew) &
                      (proc_insn_i.vm ? '1 : rsp_i.mask);

  assign result_req_o  = (cnt_q != '0);
  assign result_o      = queue_q[rd_pnt_q];
  assign commit_fire_o = result_req_o & result_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (proc_fire_o) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (commit_fire_o) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + (PtrW+1)'(proc_fire_o) - (PtrW+1)'(commit_fire_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (proc_fire_o) begin
      queue_q[wr_pnt_q].id    <= proc_insn_i.id;
      queue_q[wr_pnt_q].addr  <= proc_insn_i.vd + word_idx;
      queue_q[wr_pnt_q].wdata <= rsp_i.result;
      queue_q[wr_pnt_q].be    <= be;
    end
  end

endmodule

// ==== source/vmul_top.sv ====
// Vector integer multiply unit for one lane
// Joins the instruction controller, element counters, multiplier and result queue

`timescale 1ns/10ps

`include "vmul_config.svh"

module vmul_top
  import vmul_op_pkg::*;
  import vmul_data_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vmul_insn_t                insn_i,
  input  logic                      insn_valid_i,
  output logic                      insn_ready_o,
  input  elem_word_u [2:0]          operand_i,
  input  logic       [2:0]          operand_valid_i,
  output logic       [2:0]          operand_ready_o,
  input  strb_t                     mask_i,
  input  logic                      mask_valid_i,
  output logic                      mask_ready_o,
  output result_t                   result_o,
  output logic                      result_req_o,
  input  logic                      result_gnt_i,
  output logic [`VMUL_NR_VINSN-1:0] vinsn_done_o
);

  vmul_insn_t issue_insn, proc_insn;
  vew_e       commit_vsew;
  vlen_t      next_issue_vl, next_proc_vl, next_commit_vl;
  vlen_t      issue_left, proc_left;
  logic       issue_last, proc_last, commit_last;
  logic       accept, issue_fire, proc_fire, commit_fire;
  logic       mul_in_valid, mul_in_ready, mul_out_valid, mul_out_ready;
  elem_word_u scalar_word;
  mul_req_t   mul_req;
  mul_rsp_t   mul_rsp;

  // Replicate the low scalar element over the word
  always_comb begin
    case (issue_insn.vsew)
      EW8:     scalar_word.dword = {8{issue_insn.scalar_op[7:0]}};
      EW16:    scalar_word.dword = {4{issue_insn.scalar_op[15:0]}};
      EW32:    scalar_word.dword = {2{issue_insn.scalar_op[31:0]}};
      default: scalar_word.dword = issue_insn.scalar_op;
    endcase
  end

  assign mul_req.a    = issue_insn.use_scalar_op ? scalar_word : operand_i[0];
  assign mul_req.b    = operand_i[1];
  assign mul_req.c    = operand_i[2];
  assign mul_req.op   = issue_insn.op;
  assign mul_req.vsew = issue_insn.vsew;
  // Tag holds the live element bytes, narrowed by the mask when masked
  assign mul_req.mask = elem_strb(issue_left, issue_insn.vsew) &
                        (issue_insn.vm ? '1 : mask_i);

  vmul_insn_ctrl vmul_insn_ctrl_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .insn_i           (insn_i),
    .insn_valid_i     (insn_valid_i),
    .insn_ready_o     (insn_ready_o),
    .operand_valid_i  (operand_valid_i),
    .operand_ready_o  (operand_ready_o),
    .mask_valid_i     (mask_valid_i),
    .mask_ready_o     (mask_ready_o),
    .mul_in_ready_i   (mul_in_ready),
    .mul_in_valid_o   (mul_in_valid),
    .issue_insn_o     (issue_insn),
    .proc_insn_o      (proc_insn),
    .commit_vsew_o    (commit_vsew),
    .next_issue_vl_o  (next_issue_vl),
    .next_proc_vl_o   (next_proc_vl),
    .next_commit_vl_o (next_commit_vl),
    .proc_fire_i      (proc_fire),
    .commit_fire_i    (commit_fire),
    .issue_last_i     (issue_last),
    .proc_last_i      (proc_last),
    .commit_last_i    (commit_last),
    .accept_o         (accept),
    .issue_fire_o     (issue_fire),
    .vinsn_done_o     (vinsn_done_o)
  );

  vmul_elem_counter vmul_elem_counter_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .accept_i         (accept),
    .new_vl_i         (insn_i.vl),
    .issue_fire_i     (issue_fire),
    .proc_fire_i      (proc_fire),
    .commit_fire_i    (commit_fire),
    .issue_vsew_i     (issue_insn.vsew),
    .proc_vsew_i      (proc_insn.vsew),
    .commit_vsew_i    (commit_vsew),
    .next_issue_vl_i  (next_issue_vl),
    .next_proc_vl_i   (next_proc_vl),
    .next_commit_vl_i (next_commit_vl),
    .issue_last_o     (issue_last),
    .proc_last_o      (proc_last),
    .commit_last_o    (commit_last),
    .issue_left_o     (issue_left),
    .proc_left_o      (proc_left)
  );

  vmul_simd_mul vmul_simd_mul_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (mul_req),
    .valid_i (mul_in_valid),
    .ready_o (mul_in_ready),
    .rsp_o   (mul_rsp),
    .valid_o (mul_out_valid),
    .ready_i (mul_out_ready)
  );

  vmul_result_queue vmul_result_queue_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rsp_i         (mul_rsp),
    .rsp_valid_i   (mul_out_valid),
    .rsp_ready_o   (mul_out_ready),
    .proc_insn_i   (proc_insn),
    .proc_left_i   (proc_left),
    .proc_fire_o   (proc_fire),
    .result_o      (result_o),
    .result_req_o  (result_req_o),
    .result_gnt_i  (result_gnt_i),
    .commit_fire_o (commit_fire)
  );

endmodule

// ==== tb/vmul_properties.sv ====
// Handshake assertions for the vector multiply unit
// Bound into the top level

`timescale 1ns/10ps

`include "vmul_config.svh"

module vmul_properties
  import vmul_data_pkg::*;
(
  input logic                      clk_i,
  input logic                      rst_ni,
  input result_t                   result_o,
  input logic                      result_req_o,
  input logic                      result_gnt_i,
  input logic [`VMUL_NR_VINSN-1:0] vinsn_done_o,
  input logic [2:0]                operand_valid_i,
  input logic [2:0]                operand_ready_o,
  input logic                      mask_valid_i,
  input logic                      mask_ready_o
);

  // Payload holds until the register file grants
  result_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_req_o && !result_gnt_i) |=> (result_req_o && $stable(result_o)))
    else $error("result_o changed while waiting for grant");

  done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(vinsn_done_o))
    else $error("more than one done bit set");

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((operand_ready_o & ~operand_valid_i) == 3'b000) && !(mask_ready_o && !mask_valid_i))
    else $error("ready raised on an input without valid");

endmodule

bind vmul_top vmul_properties vmul_properties_inst (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .result_o        (result_o),
  .result_req_o    (result_req_o),
  .result_gnt_i    (result_gnt_i),
  .vinsn_done_o    (vinsn_done_o),
  .operand_valid_i (operand_valid_i),
  .operand_ready_o (operand_ready_o),
  .mask_valid_i    (mask_valid_i),
  .mask_ready_o    (mask_ready_o)
);

// ==== tb/vmul_tb.sv ====
// Directed testbench for the vector integer multiply unit
// Drives instructions and operands, models the results and checks the write port

`timescale 1ns/10ps

`include "vmul_config.svh"

module vmul_tb
  import vmul_op_pkg::*;
  import vmul_data_pkg::*;
();

  // Words over all tests, sizes the watchdog
  localparam int TotalWords = 27;

  logic                      clk_i;
  logic                      rst_ni;
  vmul_insn_t                insn_i;
  logic                      insn_valid_i;
  logic                      insn_ready_o;
  elem_word_u [2:0]          operand_i;
  logic       [2:0]          operand_valid_i;
  logic       [2:0]          operand_ready_o;
  strb_t                     mask_i;
  logic                      mask_valid_i;
  logic                      mask_ready_o;
  result_t                   result_o;
  logic                      result_req_o;
  logic                      result_gnt_i;
  logic [`VMUL_NR_VINSN-1:0] vinsn_done_o;

  // Pending stimulus per port and expected writes in order
  vmul_insn_t insn_q[$];
  elem_word_u vs1_q[$];
  elem_word_u vs2_q[$];
  elem_word_u vd_q[$];
  strb_t      mask_q[$];
  result_t    exp_q[$];
  logic       last_q[$];

  integer                    seed = 79;
  int                        errors = 0;
  int                        tests = 0;
  int                        next_id = 0;
  int                        gnt_mode = 1;
  logic                      no_vs1_check = 1'b0;
  logic [`VMUL_NR_VINSN-1:0] exp_done;

  vmul_top vmul_top_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .insn_ready_o    (insn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .result_o        (result_o),
    .result_req_o    (result_req_o),
    .result_gnt_i    (result_gnt_i),
    .vinsn_done_o    (vinsn_done_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [63:0] lane_mask(input int w);
    return (w == 64) ? 64'hffff_ffff_ffff_ffff : (64'd1 << w) - 64'd1;
  endfunction

  // Low scalar element copied into every lane
  function automatic logic [63:0] replicate(input logic [63:0] s, input vew_e vsew);
    int          w;
    logic [63:0] r;
    w = 8 << vsew;
    r = '0;
    for (int i = 0; i < 64; i += w) begin
      r = r | ((s & lane_mask(w)) << i);
    end
    return r;
  endfunction

  // Lane-wise product, modulo the element width
  function automatic logic [63:0] model_word(input vmul_op_e op, input vew_e vsew,
                                             input logic [63:0] a, b, c);
    int           w;
    logic [63:0]  m, r, res;
    logic [127:0] p;
    w   = 8 << vsew;
    m   = lane_mask(w);
    res = '0;
    for (int i = 0; i < 64; i += w) begin
      p = {64'h0, (a >> i) & m} * {64'h0, (b >> i) & m};
      case (op)
        VMULHU:  r = 64'(p >> w) & m;
        VMACC:   r = (p[63:0] + ((c >> i) & m)) & m;
        default: r = p[63:0] & m;
      endcase
      res = res | (r << i);
    end
    return res;
  endfunction

  task automatic check_result(input string name, input result_t exp, input result_t act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_done(input string name, input logic [`VMUL_NR_VINSN-1:0] exp,
                            input logic [`VMUL_NR_VINSN-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - start_err);
  endtask

  // Queues one instruction, its operand words and the writes it should produce
  task automatic send_insn(input vmul_op_e op, input vew_e vsew, input int vl,
                           input vaddr_t vd, input logic vm, input logic use_scalar);
    vmul_insn_t insn;
    result_t    exp;
    elem_word_u a, b, c;
    strb_t      mask;
    int         per, nwords, left, n;
    insn.id            = vid_t'(next_id);
    insn.op            = op;
    insn.vsew          = vsew;
    insn.vl            = vlen_t'(vl);
    insn.vd            = vd;
    insn.vm            = vm;
    insn.use_scalar_op = use_scalar;
    insn.scalar_op     = {$random(seed), $random(seed)};
    next_id++;
    insn_q.push_back(insn);
    per    = 8 >> vsew;
    nwords = (vl + per - 1) / per;
    for (int k = 0; k < nwords; k++) begin
      a.dword = use_scalar ? replicate(insn.scalar_op, vsew) : {$random(seed), $random(seed)};
      b.dword = {$random(seed), $random(seed)};
      c.dword = {$random(seed), $random(seed)};
      mask    = strb_t'($random(seed));
      if (!use_scalar) begin
        vs1_q.push_back(a);
      end
      vs2_q.push_back(b);
      if (op == VMACC) begin
        vd_q.push_back(c);
      end
      if (!vm) begin
        mask_q.push_back(mask);
      end
      left = vl - k * per;
      n    = (left < per) ? left : per;
      exp.id          = insn.id;
      exp.addr        = vd + vaddr_t'(k);
      exp.wdata.dword = model_word(op, vsew, a.dword, b.dword, c.dword);
      exp.be          = strb_t'((1 << (n << vsew)) - 1);
      if (!vm) begin
        exp.be = exp.be & mask;
      end
      exp_q.push_back(exp);
      last_q.push_back(k == nwords - 1);
    end
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Error at %0t: %0d results still missing after %0d cycles",
               $time, exp_q.size(), max_cycles);
      errors++;
    end
  endtask

  task automatic test_reset();
    int start_err;
    start_err = errors;
    @(negedge clk_i);
    check_ready("insn_ready_o", 1'b1, insn_ready_o);
    check_ready("result_req_o", 1'b0, result_req_o);
    check_ready("mask_ready_o", 1'b0, mask_ready_o);
    for (int p = 0; p < 3; p++) begin
      check_ready($sformatf("operand_ready_o[%0d]", p), 1'b0, operand_ready_o[p]);
    end
    check_done("vinsn_done_o", '0, vinsn_done_o);
    report_test("after reset", start_err);
  endtask

  task automatic test_vmul_vv();
    int start_err;
    int vls [4] = '{13, 10, 5, 3};
    start_err = errors;
    @(negedge clk_i);
    gnt_mode = 1;
    for (int ew = 0; ew < 4; ew++) begin
      send_insn(VMUL, vew_e'(ew), vls[ew], vaddr_t'(16 + 16 * ew), 1'b1, 1'b0);
    end
    wait_drained(11 * 40);
    report_test("vmul vector-vector", start_err);
  endtask

  task automatic test_vmulhu_scalar();
    int start_err;
    start_err = errors;
    @(negedge clk_i);
    no_vs1_check = 1'b1;
    send_insn(VMULHU, EW16, 11, 8'h60, 1'b1, 1'b1);
    wait_drained(3 * 40);
    no_vs1_check = 1'b0;
    report_test("vmulhu scalar ew16", start_err);
  endtask

  task automatic test_masked_vmacc();
    int start_err;
    start_err = errors;
    @(negedge clk_i);
    gnt_mode = 2;
    send_insn(VMACC, EW8, 19, 8'h80, 1'b0, 1'b0);
    wait_drained(3 * 40);
    report_test("masked vmacc", start_err);
  endtask

  task automatic test_backpressure();
    int start_err;
    int n;
    start_err = errors;
    @(negedge clk_i);
    gnt_mode = 0;
    next_id  = 0;
    for (int i = 0; i < 5; i++) begin
      send_insn(VMUL, EW32, 3, vaddr_t'(8'ha0 + 4 * i), 1'b1, 1'b0);
    end
    n = 0;
    while (insn_q.size() > 1 && n < 100) begin
      @(negedge clk_i);
      n++;
    end
    if (insn_q.size() > 1) begin
      $display("Error at %0t: only %0d instructions accepted while the grant is low",
               $time, 5 - insn_q.size());
      errors++;
    end
    // A full queue keeps the fifth instruction waiting
    for (int c = 0; c < 5; c++) begin
      check_ready("insn_ready_o", 1'b0, insn_ready_o);
      @(negedge clk_i);
    end
    if (insn_q.size() != 1) begin
      $display("Error at %0t: expected one instruction held back, %0d are waiting",
               $time, insn_q.size());
      errors++;
    end
    gnt_mode = 2;
    wait_drained(10 * 40);
    report_test("back-pressure and ordering", start_err);
  endtask

  // Input driver, advances each port after a handshake
  always @(posedge clk_i) begin
    if (insn_valid_i && insn_ready_o) begin
      void'(insn_q.pop_front());
    end
    if (operand_valid_i[0] && operand_ready_o[0]) begin
      void'(vs1_q.pop_front());
    end
    if (operand_valid_i[1] && operand_ready_o[1]) begin
      void'(vs2_q.pop_front());
    end
    if (operand_valid_i[2] && operand_ready_o[2]) begin
      void'(vd_q.pop_front());
    end
    if (mask_valid_i && mask_ready_o) begin
      void'(mask_q.pop_front());
    end
    insn_valid_i       <= (insn_q.size() != 0);
    operand_valid_i[0] <= (vs1_q.size() != 0);
    operand_valid_i[1] <= (vs2_q.size() != 0);
    operand_valid_i[2] <= (vd_q.size() != 0);
    mask_valid_i       <= (mask_q.size() != 0);
    if (insn_q.size() != 0) begin
      insn_i <= insn_q[0];
    end
    if (vs1_q.size() != 0) begin
      operand_i[0] <= vs1_q[0];
    end
    if (vs2_q.size() != 0) begin
      operand_i[1] <= vs2_q[0];
    end
    if (vd_q.size() != 0) begin
      operand_i[2] <= vd_q[0];
    end
    if (mask_q.size() != 0) begin
      mask_i <= mask_q[0];
    end
    case (gnt_mode)
      0:       result_gnt_i <= 1'b0;
      1:       result_gnt_i <= 1'b1;
      default: result_gnt_i <= 1'($random(seed));
    endcase
  end

  // Write port monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      exp_done = '0;
      if (result_req_o && result_gnt_i) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: result written with none expected", $time);
          errors++;
        end else begin
          check_result("result_o", exp_q[0], result_o);
          if (last_q[0]) begin
            exp_done[exp_q[0].id] = 1'b1;
          end
          void'(exp_q.pop_front());
          void'(last_q.pop_front());
        end
      end
      check_done("vinsn_done_o", exp_done, vinsn_done_o);
      if (no_vs1_check) begin
        check_ready("operand_ready_o[0]", 1'b0, operand_ready_o[0]);
      end
    end
  end

  initial begin
    repeat (TotalWords * 40) @(posedge clk_i);
    $display("Watchdog expired at %0t with %0d results outstanding", $time, exp_q.size());
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    insn_i          = '0;
    insn_valid_i    = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    mask_i          = '0;
    mask_valid_i    = 1'b0;
    result_gnt_i    = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset();
    test_vmul_vv();
    test_vmulhu_scalar();
    test_masked_vmacc();
    test_backpressure();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+source
source/vmul_op_pkg.sv
source/vmul_data_pkg.sv
source/vmul_insn_ctrl.sv
source/vmul_elem_counter.sv
source/vmul_simd_mul.sv
source/vmul_result_queue.sv
source/vmul_top.sv
tb/vmul_properties.sv
tb/vmul_tb.sv

// ==== Bender.yml ====
package:
  name: vmul

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/vmul_op_pkg.sv
      - source/vmul_data_pkg.sv
      - source/vmul_insn_ctrl.sv
      - source/vmul_elem_counter.sv
      - source/vmul_simd_mul.sv
      - source/vmul_result_queue.sv
      - source/vmul_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/vmul_properties.sv
      - tb/vmul_tb.sv
